// File: common/cmd_cfg_settings.svh
`ifndef CMD_CFG_SETTINGS_SVH
`define CMD_CFG_SETTINGS_SVH

// Sample queue geometry
`define CMD_CFG_ENTRIES        384                    // Samples per channel queue
`define CMD_CFG_ADDR_W         9                      // Queue address width
`define CMD_CFG_TRIG_POS_H_W   (`CMD_CFG_ADDR_W - 8)  // Bits above the low byte
`define CMD_CFG_NUM_CH         5                      // Capture channels

`define CMD_CFG_RESP_ACK       8'hA5                  // Positive acknowledge
`define CMD_CFG_RESP_NAK       8'hEE                  // Negative acknowledge

// Register map, host address order
`define CMD_CFG_ADDR_TRIG_CFG    6'h00
`define CMD_CFG_ADDR_CH1_TRIG    6'h01
`define CMD_CFG_ADDR_CH2_TRIG    6'h02
`define CMD_CFG_ADDR_CH3_TRIG    6'h03
`define CMD_CFG_ADDR_CH4_TRIG    6'h04
`define CMD_CFG_ADDR_CH5_TRIG    6'h05
`define CMD_CFG_ADDR_DECIMATOR   6'h06
`define CMD_CFG_ADDR_VIH         6'h07
`define CMD_CFG_ADDR_VIL         6'h08
`define CMD_CFG_ADDR_MATCH_H     6'h09
`define CMD_CFG_ADDR_MATCH_L     6'h0A
`define CMD_CFG_ADDR_MASK_H      6'h0B
`define CMD_CFG_ADDR_MASK_L      6'h0C
`define CMD_CFG_ADDR_BAUD_H      6'h0D
`define CMD_CFG_ADDR_BAUD_L      6'h0E
`define CMD_CFG_ADDR_TRIG_POS_H  6'h0F
`define CMD_CFG_ADDR_TRIG_POS_L  6'h10

// Reset values, sized to each register
`define CMD_CFG_RST_TRIG_CFG     6'h03
`define CMD_CFG_RST_CH_TRIG      5'h01                // Same for all five channels
`define CMD_CFG_RST_DECIMATOR    4'h0
`define CMD_CFG_RST_VIH          8'hAA
`define CMD_CFG_RST_VIL          8'h55
`define CMD_CFG_RST_MATCH_H      8'h00
`define CMD_CFG_RST_MATCH_L      8'h00
`define CMD_CFG_RST_MASK_H       8'h00
`define CMD_CFG_RST_MASK_L       8'h00
`define CMD_CFG_RST_BAUD_H       8'h06
`define CMD_CFG_RST_BAUD_L       8'hC8
`define CMD_CFG_RST_TRIG_POS_H   ((`CMD_CFG_TRIG_POS_H_W)'(1'b0))
`define CMD_CFG_RST_TRIG_POS_L   8'h01

`endif

// File: common/cmd_cfg_pkg.sv
`default_nettype none

`include "cmd_cfg_settings.svh"

package cmd_cfg_pkg;

  // Host opcode, top two bits of the command word
  typedef enum logic [1:0] {
    op_read  = 2'b00,  // Register read
    op_write = 2'b01,  // Register write
    op_dump  = 2'b10,  // Channel dump
    op_bad   = 2'b11   // Reserved, answered with NAK
  } cmd_op_e;

  typedef logic [5:0] reg_addr_t;                      // Register address
  typedef logic [2:0] chan_sel_t;                      // Channel number, 1 to 5 legal
  typedef logic [`CMD_CFG_ADDR_W-1:0] qaddr_t;         // Sample queue address

  // Read data of all queues, indexed by channel number
  typedef logic [`CMD_CFG_NUM_CH:1][7:0] ch_bytes_t;

  // 16-bit host command as delivered by the UART
  typedef struct packed {
    cmd_op_e   op;    // Bits 15:14
    reg_addr_t addr;  // Bits 13:8, low 3 bits pick the dump channel
    logic [7:0] data; // Write datum
  } host_cmd_t;

  // Single-cycle register write request
  typedef struct packed {
    logic       en;
    reg_addr_t  addr;
    logic [7:0] data;
  } reg_wr_t;

  // Everything the rest of the analyzer sees
  typedef struct packed {
    logic [5:0]                    trig_cfg;     // Trigger and capture control
    logic [`CMD_CFG_NUM_CH:1][4:0] ch_trig_cfg;  // Per-channel trigger config
    logic [3:0]                    decimator;    // Sample rate divider
    logic [7:0]                    vih;          // High threshold PWM
    logic [7:0]                    vil;          // Low threshold PWM
    logic [15:0]                   match;        // Protocol trigger match
    logic [15:0]                   mask;         // Protocol trigger mask
    logic [15:0]                   baud_cnt;     // UART trigger baud count
    qaddr_t                        trig_pos;     // Samples kept after trigger
  } cfg_t;

endpackage

`default_nettype wire

// File: cfg_regfile/cfg_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cmd_cfg_settings.svh"

module cfg_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cmd_cfg_pkg::reg_wr_t   reg_wr,   // From sequencer WRITE state
  input  cmd_cfg_pkg::reg_addr_t rd_addr,
  output logic [7:0]             rd_data,  // Combinational read
  output cmd_cfg_pkg::cfg_t      cfg       // Registers themselves
);

  // Write decode, one register per address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.trig_cfg    <= `CMD_CFG_RST_TRIG_CFG;
      cfg.ch_trig_cfg <= {`CMD_CFG_NUM_CH{`CMD_CFG_RST_CH_TRIG}};  // All channels alike
      cfg.decimator   <= `CMD_CFG_RST_DECIMATOR;
      cfg.vih         <= `CMD_CFG_RST_VIH;
      cfg.vil         <= `CMD_CFG_RST_VIL;
      cfg.match       <= {`CMD_CFG_RST_MATCH_H, `CMD_CFG_RST_MATCH_L};
      cfg.mask        <= {`CMD_CFG_RST_MASK_H, `CMD_CFG_RST_MASK_L};
      cfg.baud_cnt    <= {`CMD_CFG_RST_BAUD_H, `CMD_CFG_RST_BAUD_L};
      cfg.trig_pos    <= {`CMD_CFG_RST_TRIG_POS_H, `CMD_CFG_RST_TRIG_POS_L};
    end else if (reg_wr.en) begin
      case (reg_wr.addr)
        `CMD_CFG_ADDR_TRIG_CFG:   cfg.trig_cfg       <= reg_wr.data[5:0];  // Top bits dropped
        `CMD_CFG_ADDR_CH1_TRIG:   cfg.ch_trig_cfg[1] <= reg_wr.data[4:0];
        `CMD_CFG_ADDR_CH2_TRIG:   cfg.ch_trig_cfg[2] <= reg_wr.data[4:0];
        `CMD_CFG_ADDR_CH3_TRIG:   cfg.ch_trig_cfg[3] <= reg_wr.data[4:0];
        `CMD_CFG_ADDR_CH4_TRIG:   cfg.ch_trig_cfg[4] <= reg_wr.data[4:0];
        `CMD_CFG_ADDR_CH5_TRIG:   cfg.ch_trig_cfg[5] <= reg_wr.data[4:0];
        `CMD_CFG_ADDR_DECIMATOR:  cfg.decimator      <= reg_wr.data[3:0];
        `CMD_CFG_ADDR_VIH:        cfg.vih            <= reg_wr.data;
        `CMD_CFG_ADDR_VIL:        cfg.vil            <= reg_wr.data;
        `CMD_CFG_ADDR_MATCH_H:    cfg.match[15:8]    <= reg_wr.data;
        `CMD_CFG_ADDR_MATCH_L:    cfg.match[7:0]     <= reg_wr.data;
        `CMD_CFG_ADDR_MASK_H:     cfg.mask[15:8]     <= reg_wr.data;
        `CMD_CFG_ADDR_MASK_L:     cfg.mask[7:0]      <= reg_wr.data;
        `CMD_CFG_ADDR_BAUD_H:     cfg.baud_cnt[15:8] <= reg_wr.data;
        `CMD_CFG_ADDR_BAUD_L:     cfg.baud_cnt[7:0]  <= reg_wr.data;
        `CMD_CFG_ADDR_TRIG_POS_H: begin
          // Only the bits above the low byte exist
          cfg.trig_pos[`CMD_CFG_ADDR_W-1:8] <= reg_wr.data[`CMD_CFG_TRIG_POS_H_W-1:0];
        end
        `CMD_CFG_ADDR_TRIG_POS_L: cfg.trig_pos[7:0]  <= reg_wr.data;
        default: ;  // Unmapped address, nothing changes
      endcase
    end
  end

  // Read mux, narrow registers come back zero extended
  always_comb begin
    case (rd_addr)
      `CMD_CFG_ADDR_TRIG_CFG:   rd_data = 8'(cfg.trig_cfg);
      `CMD_CFG_ADDR_CH1_TRIG:   rd_data = 8'(cfg.ch_trig_cfg[1]);
      `CMD_CFG_ADDR_CH2_TRIG:   rd_data = 8'(cfg.ch_trig_cfg[2]);
      `CMD_CFG_ADDR_CH3_TRIG:   rd_data = 8'(cfg.ch_trig_cfg[3]);
      `CMD_CFG_ADDR_CH4_TRIG:   rd_data = 8'(cfg.ch_trig_cfg[4]);
      `CMD_CFG_ADDR_CH5_TRIG:   rd_data = 8'(cfg.ch_trig_cfg[5]);
      `CMD_CFG_ADDR_DECIMATOR:  rd_data = 8'(cfg.decimator);
      `CMD_CFG_ADDR_VIH:        rd_data = cfg.vih;
      `CMD_CFG_ADDR_VIL:        rd_data = cfg.vil;
      `CMD_CFG_ADDR_MATCH_H:    rd_data = cfg.match[15:8];
      `CMD_CFG_ADDR_MATCH_L:    rd_data = cfg.match[7:0];
      `CMD_CFG_ADDR_MASK_H:     rd_data = cfg.mask[15:8];
      `CMD_CFG_ADDR_MASK_L:     rd_data = cfg.mask[7:0];
      `CMD_CFG_ADDR_BAUD_H:     rd_data = cfg.baud_cnt[15:8];
      `CMD_CFG_ADDR_BAUD_L:     rd_data = cfg.baud_cnt[7:0];
      `CMD_CFG_ADDR_TRIG_POS_H: rd_data = 8'(cfg.trig_pos[`CMD_CFG_ADDR_W-1:8]);
      `CMD_CFG_ADDR_TRIG_POS_L: rd_data = cfg.trig_pos[7:0];
      default:                  rd_data = 8'h00;  // Hole in the map
    endcase
  end

  // Sequencer passes through ACK between writes, so requests never merge
  a_wr_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    reg_wr.en |=> !reg_wr.en
  ) else $error("back-to-back register write");

endmodule

`default_nettype wire

// File: design/dump_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "cmd_cfg_settings.svh"

module dump_reader (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dump_start,  // Load pointer from waddr
  input  logic                   dump_step,   // Advance to next sample
  input  cmd_cfg_pkg::chan_sel_t dump_chan,
  input  cmd_cfg_pkg::qaddr_t    waddr,       // Capture write pointer
  output cmd_cfg_pkg::qaddr_t    raddr,       // Shared by all five queues
  input  cmd_cfg_pkg::ch_bytes_t rdata_ch,    // Same-cycle queue data
  output logic [7:0]             dump_byte,
  output logic                   dump_last,   // Current byte ends the dump
  output logic                   chan_ok      // Channel 1 to 5
);

  import cmd_cfg_pkg::*;

  qaddr_t raddr_inc;  // Next address with wrap

  assign raddr_inc = (raddr == qaddr_t'(`CMD_CFG_ENTRIES - 1)) ? '0 : raddr + 1'b1;

  // Queue read pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      raddr <= '0;
    end else if (dump_start) begin
      raddr <= waddr;      // Oldest sample sits at the write pointer
    end else if (dump_step) begin
      raddr <= raddr_inc;
    end
  end

  // Wrapped once around when the next address meets waddr again
  assign dump_last = (raddr_inc == waddr);

  assign chan_ok = (dump_chan >= chan_sel_t'(1)) &&
                   (dump_chan <= chan_sel_t'(`CMD_CFG_NUM_CH));

  // Channel byte select
  always_comb begin
    case (dump_chan)
      3'd1:    dump_byte = rdata_ch[1];
      3'd2:    dump_byte = rdata_ch[2];
      3'd3:    dump_byte = rdata_ch[3];
      3'd4:    dump_byte = rdata_ch[4];
      3'd5:    dump_byte = rdata_ch[5];
      default: dump_byte = 8'h00;  // Illegal channel, never sent
    endcase
  end

  // Holds only while the capture side keeps waddr inside the queue
  a_raddr_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    raddr < qaddr_t'(`CMD_CFG_ENTRIES)
  ) else $error("raddr beyond queue depth");

endmodule

`default_nettype wire

// File: design/cmd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "cmd_cfg_settings.svh"

module cmd_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cmd_cfg_pkg::host_cmd_t cmd,          // Stable while cmd_rdy
  input  logic                   cmd_rdy,
  output logic                   clr_cmd_rdy,  // One-cycle release to host
  output logic [7:0]             resp,
  output logic                   send_resp,    // Starts one transmit
  input  logic                   resp_sent,    // Transmit finished
  output cmd_cfg_pkg::reg_wr_t   reg_wr,
  output cmd_cfg_pkg::reg_addr_t rd_addr,
  input  logic [7:0]             rd_data,
  output logic                   dump_start,
  output logic                   dump_step,
  output cmd_cfg_pkg::chan_sel_t dump_chan,
  input  logic [7:0]             dump_byte,
  input  logic                   dump_last,
  input  logic                   chan_ok
);

  import cmd_cfg_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_write,      // Register write strobe
    st_ack,        // A5 after write
    st_nak,        // EE for bad opcode or channel
    st_read,       // Register value out
    st_dump_send,  // One dump byte out
    st_dump_wait   // Back-pressure from transmitter
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   clr_nxt;  // Registered release request

  // Command fields go straight to the register bank and queue reader
  assign rd_addr   = cmd.addr;
  assign dump_chan = cmd.addr[2:0];
  assign reg_wr    = '{en: (state == st_write), addr: cmd.addr, data: cmd.data};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      clr_cmd_rdy <= 1'b0;
    end else begin
      state       <= state_nxt;
      clr_cmd_rdy <= clr_nxt;
    end
  end

  // Next state and strobes
  always_comb begin
    state_nxt  = state;
    clr_nxt    = 1'b0;
    dump_start = 1'b0;
    dump_step  = 1'b0;
    case (state)
      st_idle: begin
        if (cmd_rdy && !clr_cmd_rdy) begin  // Host still dropping the old one
          case (cmd.op)
            op_read: begin
              state_nxt = st_read;
              clr_nxt   = 1'b1;
            end
            op_write: begin
              state_nxt = st_write;
            end
            op_dump: begin
              if (chan_ok) begin
                state_nxt  = st_dump_send;
                dump_start = 1'b1;        // raddr <= waddr
              end else begin
                state_nxt = st_nak;
                clr_nxt   = 1'b1;
              end
            end
            default: begin
              state_nxt = st_nak;
              clr_nxt   = 1'b1;
            end
          endcase
        end
      end
      st_write: begin
        state_nxt = st_ack;
        clr_nxt   = 1'b1;               // Release with the ACK
      end
      st_ack, st_nak, st_read: begin
        state_nxt = st_idle;            // No wait on resp_sent here
      end
      st_dump_send: begin
        state_nxt = st_dump_wait;
      end
      st_dump_wait: begin
        if (resp_sent) begin
          if (dump_last) begin
            state_nxt = st_idle;
            clr_nxt   = 1'b1;           // Final byte is gone
          end else begin
            state_nxt = st_dump_send;
            dump_step = 1'b1;
          end
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  assign send_resp = (state == st_read) || (state == st_ack) ||
                     (state == st_nak) || (state == st_dump_send);

  // Response byte select
  always_comb begin
    case (state)
      st_read:      resp = rd_data;
      st_ack:       resp = `CMD_CFG_RESP_ACK;
      st_nak:       resp = `CMD_CFG_RESP_NAK;
      st_dump_send: resp = dump_byte;
      default:      resp = 8'h00;
    endcase
  end

  a_send_gap : assert property (
    @(posedge clk) disable iff (!rst_n)
    send_resp |=> !send_resp
  ) else $error("send_resp high two cycles");

  a_clr_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |=> !clr_cmd_rdy
  ) else $error("clr_cmd_rdy longer than one cycle");

endmodule

`default_nettype wire

// File: design/cmd_cfg_top.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_cfg_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cmd_cfg_pkg::host_cmd_t cmd,          // From UART receiver
  input  logic                   cmd_rdy,
  output logic                   clr_cmd_rdy,
  output logic [7:0]             resp,         // To UART transmitter
  output logic                   send_resp,
  input  logic                   resp_sent,
  input  cmd_cfg_pkg::qaddr_t    waddr,        // Capture write pointer
  output cmd_cfg_pkg::qaddr_t    raddr,        // To all sample queues
  input  cmd_cfg_pkg::ch_bytes_t rdata_ch,
  output cmd_cfg_pkg::cfg_t      cfg           // To trigger and capture logic
);

  import cmd_cfg_pkg::*;

  reg_wr_t    reg_wr;
  reg_addr_t  rd_addr;
  logic [7:0] rd_data;
  logic       dump_start;
  logic       dump_step;
  chan_sel_t  dump_chan;
  logic [7:0] dump_byte;
  logic       dump_last;
  logic       chan_ok;

  cmd_sequencer u_seq (
    .clk, .rst_n, .cmd, .cmd_rdy, .clr_cmd_rdy, .resp, .send_resp, .resp_sent,
    .reg_wr, .rd_addr, .rd_data,
    .dump_start, .dump_step, .dump_chan, .dump_byte, .dump_last, .chan_ok
  );

  cfg_regfile u_regs (
    .clk, .rst_n, .reg_wr, .rd_addr, .rd_data, .cfg
  );

  dump_reader u_dump (
    .clk, .rst_n, .dump_start, .dump_step, .dump_chan,
    .waddr, .raddr, .rdata_ch, .dump_byte, .dump_last, .chan_ok
  );

endmodule

`default_nettype wire

// File: testbench/tb_cmd_cfg.sv
`timescale 1ns/1ns
`default_nettype none

`include "cmd_cfg_settings.svh"

module tb_cmd_cfg;

  import cmd_cfg_pkg::*;

  localparam int RESP_LIMIT = 40;  // Cycles allowed per awaited event
  localparam int NUM_REGS   = 17;

  logic       clk;
  logic       rst_n;
  host_cmd_t  cmd;
  logic       cmd_rdy;
  logic       clr_cmd_rdy;
  logic [7:0] resp;
  logic       send_resp;
  logic       resp_sent;
  qaddr_t     waddr;
  qaddr_t     raddr;
  ch_bytes_t  rdata_ch;
  cfg_t       cfg;

  logic [7:0] exp_reg [NUM_REGS];  // Register mirror, already truncated
  logic       tx_busy;             // Byte in flight in transmitter model

  cmd_cfg_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;         // 10 ns period
  end

  // Queue content: low byte of address times 3 plus channel
  function automatic logic [7:0] queue_byte(input qaddr_t a, input int c);
    return 8'(int'(a) * 3 + c);
  endfunction

  always_comb begin
    for (int c = 1; c <= `CMD_CFG_NUM_CH; c++) rdata_ch[c] = queue_byte(raddr, c);
  end

  // Implemented bits of each register
  function automatic logic [7:0] reg_mask(input int a);
    if (a == 0) return 8'h3F;
    if (a >= 1 && a <= 5) return 8'h1F;
    if (a == 6) return 8'h0F;
    if (a == 15) return 8'((1 << (`CMD_CFG_ADDR_W - 8)) - 1);
    if (a < NUM_REGS) return 8'hFF;
    return 8'h00;                  // Unmapped
  endfunction

  function automatic cfg_t expected_cfg();
    cfg_t e;
    e.trig_cfg = exp_reg[0][5:0];
    for (int c = 1; c <= `CMD_CFG_NUM_CH; c++) e.ch_trig_cfg[c] = exp_reg[c][4:0];
    e.decimator = exp_reg[6][3:0];
    e.vih       = exp_reg[7];
    e.vil       = exp_reg[8];
    e.match     = {exp_reg[9], exp_reg[10]};
    e.mask      = {exp_reg[11], exp_reg[12]};
    e.baud_cnt  = {exp_reg[13], exp_reg[14]};
    e.trig_pos  = qaddr_t'({exp_reg[15], exp_reg[16]});  // High bits above low byte
    return e;
  endfunction

  task automatic fail_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on first failure");
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    fail_run();
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    fail_run();
  endtask

  // Transmitter, resp_sent 1 to 8 cycles after each byte
  initial begin
    int unsigned delay;
    resp_sent = 1'b0;
    tx_busy   = 1'b0;
    forever begin
      @(posedge clk);
      if (send_resp) begin
        tx_busy <= 1'b1;
        delay = $urandom_range(8, 1);
        repeat (delay) @(negedge clk);
        resp_sent = 1'b1;
        @(negedge clk);
        resp_sent = 1'b0;
        tx_busy   <= 1'b0;
      end
    end
  end

  // No new byte while the previous one is still in flight
  always @(posedge clk) begin
    if (rst_n && send_resp) begin
      assert (!tx_busy) else report_error("send_resp before resp_sent of previous byte");
    end
  end

  // Host issues one command and waits for its single response
  task automatic send_cmd(input cmd_op_e op, input reg_addr_t addr, input logic [7:0] data,
                          input int latency, output logic [7:0] rsp);
    int n;
    @(negedge clk);
    cmd     = '{op: op, addr: addr, data: data};
    cmd_rdy = 1'b1;
    @(posedge clk);
    n = 1;
    while (!send_resp) begin
      if (n >= RESP_LIMIT) timeout_fail("no send_resp for host command");
      @(posedge clk);
      n++;
    end
    rsp = resp;
    assert (n == latency)
      else report_error($sformatf("response after %0d cycles, expected %0d", n, latency));
    assert (clr_cmd_rdy) else report_error("clr_cmd_rdy missing with single response");
    @(negedge clk);
    cmd_rdy = 1'b0;                // Host drops after release
    n = 0;
    while (tx_busy) begin          // Host serializes on the transmitter
      if (n >= RESP_LIMIT) timeout_fail("transmitter never finished the byte");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic check_read(input reg_addr_t addr, input logic [7:0] expected);
    logic [7:0] rsp;
    send_cmd(op_read, addr, 8'($urandom), 2, rsp);
    assert (rsp == expected) else report_error(
      $sformatf("read of %02h returned %02h, expected %02h", addr, rsp, expected));
  endtask

  task automatic check_write(input reg_addr_t addr, input logic [7:0] data);
    logic [7:0] rsp;
    send_cmd(op_write, addr, data, 3, rsp);
    assert (rsp == `CMD_CFG_RESP_ACK)
      else report_error($sformatf("write of %02h answered %02h", addr, rsp));
    if (addr < NUM_REGS) exp_reg[addr] = data & reg_mask(addr);
  endtask

  task automatic check_nak(input cmd_op_e op, input reg_addr_t addr);
    logic [7:0] rsp;
    send_cmd(op, addr, 8'($urandom), 2, rsp);
    assert (rsp == `CMD_CFG_RESP_NAK)
      else report_error($sformatf("op %0d addr %02h answered %02h", op, addr, rsp));
  endtask

  task automatic check_cfg();
    cfg_t e;
    e = expected_cfg();
    assert (cfg == e) else report_error($sformatf("cfg %h, expected %h", cfg, e));
  endtask

  // Whole-queue dump, paced by the transmitter model
  task automatic run_dump(input chan_sel_t ch, input qaddr_t start);
    int     count;
    int     t;
    qaddr_t a;
    logic   done;
    @(negedge clk);
    waddr   = start;
    cmd     = '{op: op_dump, addr: reg_addr_t'(ch), data: 8'($urandom)};
    cmd_rdy = 1'b1;
    count   = 0;
    a       = start;               // Oldest sample first
    done    = 1'b0;
    t       = 0;
    while (!done) begin
      @(posedge clk);
      t++;
      if (t > RESP_LIMIT) timeout_fail("dump stalled between bytes");
      if (send_resp) begin
        assert (count < `CMD_CFG_ENTRIES) else report_error("dump sent an extra byte");
        assert (raddr == a) else report_error(
          $sformatf("raddr %0d during dump, expected %0d", raddr, a));
        assert (resp == queue_byte(a, ch)) else report_error($sformatf(
          "ch %0d addr %0d gave %02h, expected %02h", ch, a, resp, queue_byte(a, ch)));
        count++;
        a = (a == qaddr_t'(`CMD_CFG_ENTRIES - 1)) ? '0 : a + 1'b1;  // Wrap at depth
        t = 0;
      end
      if (clr_cmd_rdy) begin
        assert (count == `CMD_CFG_ENTRIES && !tx_busy) else report_error(
          $sformatf("dump released after %0d bytes or before final resp_sent", count));
        done = 1'b1;
      end
    end
    @(negedge clk);
    cmd_rdy = 1'b0;
  endtask

  initial begin
    cfg_t snap;
    void'($urandom(86147));
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_rdy = 1'b0;
    waddr   = '0;
    exp_reg[0]  = 8'(`CMD_CFG_RST_TRIG_CFG);
    for (int c = 1; c <= 5; c++) exp_reg[c] = 8'(`CMD_CFG_RST_CH_TRIG);
    exp_reg[6]  = 8'(`CMD_CFG_RST_DECIMATOR);
    exp_reg[7]  = `CMD_CFG_RST_VIH;
    exp_reg[8]  = `CMD_CFG_RST_VIL;
    exp_reg[9]  = `CMD_CFG_RST_MATCH_H;
    exp_reg[10] = `CMD_CFG_RST_MATCH_L;
    exp_reg[11] = `CMD_CFG_RST_MASK_H;
    exp_reg[12] = `CMD_CFG_RST_MASK_L;
    exp_reg[13] = `CMD_CFG_RST_BAUD_H;
    exp_reg[14] = `CMD_CFG_RST_BAUD_L;
    exp_reg[15] = 8'(`CMD_CFG_RST_TRIG_POS_H);
    exp_reg[16] = `CMD_CFG_RST_TRIG_POS_L;
    repeat (4) @(negedge clk);     // 4 cycles of reset
    rst_n = 1'b1;

    for (int a = 0; a < NUM_REGS; a++) check_read(reg_addr_t'(a), exp_reg[a]);
    check_cfg();                   // Reset values

    for (int a = 0; a < NUM_REGS; a++) begin
      check_write(reg_addr_t'(a), 8'($urandom));
      check_read(reg_addr_t'(a), exp_reg[a]);
      check_cfg();
    end
    for (int a = 0; a < NUM_REGS; a++) check_read(reg_addr_t'(a), exp_reg[a]);

    check_read(6'h11, 8'h00);      // Holes in the map
    check_read(6'h3F, 8'h00);
    snap = cfg;
    check_write(6'h2A, 8'($urandom));
    assert (cfg == snap) else report_error("write to unmapped address changed cfg");
    check_cfg();

    check_nak(op_bad, reg_addr_t'($urandom));
    check_nak(op_dump, {3'($urandom), 3'd0});  // Illegal channels
    check_nak(op_dump, {3'($urandom), 3'd6});
    check_nak(op_dump, {3'($urandom), 3'd7});

    for (int c = 1; c <= `CMD_CFG_NUM_CH; c++) begin
      run_dump(chan_sel_t'(c), (c == 5) ? qaddr_t'(`CMD_CFG_ENTRIES - 1)
                                        : qaddr_t'($urandom_range(`CMD_CFG_ENTRIES - 1, 0)));
    end
    check_cfg();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: cmd_cfg_top.f
+incdir+common
common/cmd_cfg_pkg.sv
cfg_regfile/cfg_regfile.sv
design/dump_reader.sv
design/cmd_sequencer.sv
design/cmd_cfg_top.sv
testbench/tb_cmd_cfg.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= cmd_cfg_top.f
RTL_TOP   ?= cmd_cfg_top
TB_TOP    ?= tb_cmd_cfg
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
